// File: src/lookup_settings.svh
////////////////////////////////////////
// Entry geometry and bus widths for the
// lookup data-fetch stage
////////////////////////////////////////

`ifndef LOOKUP_SETTINGS_SVH
`define LOOKUP_SETTINGS_SVH

// Hash selects the entry and index selects the word in it
`define LK_HASH_WIDTH       8
`define LK_IDX_WIDTH        3
`define LK_SRAM_ADDR_WIDTH  (`LK_HASH_WIDTH + `LK_IDX_WIDTH)
`define LK_WORD_WIDTH       64

// Entry layout with rule words first
`define LK_NUM_RULE_WORDS   6
`define LK_NUM_DATA_WORDS   2

`endif

// File: src/lookup_types_pkg.sv
////////////////////////////////////////
// Vector types for hashes, SRAM
// addresses, words and entry data
////////////////////////////////////////

`include "lookup_settings.svh"

package lookup_types_pkg;

   typedef logic [`LK_HASH_WIDTH-1:0] entry_hash_t;

   // Word position inside one entry
   typedef logic [`LK_IDX_WIDTH-1:0] word_idx_t;

   // {hash, index}
   typedef logic [`LK_SRAM_ADDR_WIDTH-1:0] sram_addr_t;

   typedef logic [`LK_WORD_WIDTH-1:0] sram_word_t;

   // First data word read lands in the low half
   typedef logic [`LK_NUM_DATA_WORDS*`LK_WORD_WIDTH-1:0] entry_data_t;

endpackage

// File: src/lookup_ctrl_pkg.sv
////////////////////////////////////////
// State encodings for the read issuer
// and the Wishbone master
////////////////////////////////////////

`include "lookup_settings.svh"

package lookup_ctrl_pkg;

   typedef enum logic [0:0] {
      WAIT_FOR_HIT,
      READ_DATA_WORDS
   } issuer_state_e;

   typedef enum logic [1:0] {
      WB_IDLE,     // Ready for a request
      WB_BUS,      // Classic cycle open until ack
      WB_RETURN    // Word handed to the collector
   } wb_state_e;

endpackage

// File: src/hit_fifo.sv
////////////////////////////////////////
// Fall-through FIFO of hit hashes
////////////////////////////////////////

`timescale 1ns/1ps
`include "lookup_settings.svh"

module hit_fifo #(
   parameter int DEPTH_BITS = 1
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          push,
   input  lookup_types_pkg::entry_hash_t push_hash,
   input  logic                          pop,
   output lookup_types_pkg::entry_hash_t head_hash,
   output logic                          empty,
   output logic                          full
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   lookup_types_pkg::entry_hash_t mem [DEPTH];

   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;
   logic                  do_push;
   logic                  do_pop;

   assign do_push = push && !full;   // Push on full is dropped
   assign do_pop  = pop && !empty;

   assign empty = (count == '0);
   assign full  = (count == (DEPTH_BITS+1)'(DEPTH));

   // Head is read straight from storage with no read latency
   assign head_hash = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= push_hash;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;   // Wraps since depth is a power of two
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: src/data_read_issuer.sv
////////////////////////////////////////
// Read issuer FSM that turns a queued
// hash into data-word read requests
////////////////////////////////////////

`timescale 1ns/1ps
`include "lookup_settings.svh"

module data_read_issuer (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          hash_empty,
   input  lookup_types_pkg::entry_hash_t hash_out,
   input  logic                          rd_rdy,
   output logic                          hash_pop,
   output logic                          rd_req,
   output lookup_types_pkg::sram_addr_t  rd_addr
);

   // Counter must reach LK_NUM_DATA_WORDS itself
   localparam int CNT_WIDTH = $clog2(`LK_NUM_DATA_WORDS + 1);

   // Data words follow the rule words
   localparam lookup_types_pkg::word_idx_t FIRST_IDX =
      lookup_types_pkg::word_idx_t'(`LK_NUM_RULE_WORDS);

   lookup_ctrl_pkg::issuer_state_e state;

   logic [CNT_WIDTH-1:0]        words_issued;
   logic [CNT_WIDTH-1:0]        words_next;
   logic                        start_entry;
   logic                        next_word;

   assign start_entry = (state == lookup_ctrl_pkg::WAIT_FOR_HIT) && !hash_empty && rd_rdy;
   assign next_word   = (state == lookup_ctrl_pkg::READ_DATA_WORDS) && rd_rdy;
   assign words_next  = words_issued + 1'b1;

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= lookup_ctrl_pkg::WAIT_FOR_HIT;
         words_issued <= '0;
         rd_req       <= 1'b0;
         hash_pop     <= 1'b0;
      end else begin
         rd_req   <= 1'b0;   // Both are single-cycle pulses
         hash_pop <= 1'b0;

         case (state)
            lookup_ctrl_pkg::WAIT_FOR_HIT: begin
               if (start_entry) begin
                  rd_req       <= 1'b1;
                  hash_pop     <= 1'b1;   // Hash now lives in rd_addr
                  words_issued <= CNT_WIDTH'(1);
                  state        <= lookup_ctrl_pkg::READ_DATA_WORDS;
               end
            end

            lookup_ctrl_pkg::READ_DATA_WORDS: begin
               if (next_word) begin
                  rd_req       <= 1'b1;
                  words_issued <= words_next;
                  if (words_next == CNT_WIDTH'(`LK_NUM_DATA_WORDS))
                     state <= lookup_ctrl_pkg::WAIT_FOR_HIT;
               end
            end

            default: state <= lookup_ctrl_pkg::WAIT_FOR_HIT;
         endcase
      end
   end

   // Request address is held between requests
   always_ff @(posedge clk) begin
      if (start_entry)
         rd_addr <= {hash_out, FIRST_IDX};
      else if (next_word)
         rd_addr <= rd_addr + 1'b1;   // Next word of the same entry
   end

endmodule

// File: src/sram_wb_master.sv
////////////////////////////////////////
// Wishbone classic read master with
// one single read per request
////////////////////////////////////////

`timescale 1ns/1ps
`include "lookup_settings.svh"

module sram_wb_master (
   input  logic                         clk,
   input  logic                         reset,

   // Request side
   input  logic                         rd_req,
   input  lookup_types_pkg::sram_addr_t rd_addr,
   output logic                         rd_rdy,

   // Wishbone side
   input  lookup_types_pkg::sram_word_t wb_dat_i,
   input  logic                         wb_ack,
   output logic                         wb_cyc,
   output logic                         wb_stb,
   output logic                         wb_we,
   output lookup_types_pkg::sram_addr_t wb_adr,

   // Returned word
   output logic                         rd_valid,
   output lookup_types_pkg::sram_word_t rd_data,
   output lookup_types_pkg::sram_addr_t rd_data_addr
);

   lookup_ctrl_pkg::wb_state_e state;

   logic take_req;
   logic bus_done;

   assign take_req = (state == lookup_ctrl_pkg::WB_IDLE) && rd_req;
   assign bus_done = (state == lookup_ctrl_pkg::WB_BUS) && wb_ack;

   // Low while a request is in flight, so it is never taken twice
   assign rd_rdy = (state == lookup_ctrl_pkg::WB_IDLE) && !rd_req;

   // Cycle stays open for the whole WB_BUS state
   assign wb_cyc = (state == lookup_ctrl_pkg::WB_BUS);
   assign wb_stb = (state == lookup_ctrl_pkg::WB_BUS);
   assign wb_we  = 1'b0;   // Read-only master

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= lookup_ctrl_pkg::WB_IDLE;
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= 1'b0;

         case (state)
            lookup_ctrl_pkg::WB_IDLE: begin
               if (take_req)
                  state <= lookup_ctrl_pkg::WB_BUS;
            end

            // Slave may stretch this for any number of cycles
            lookup_ctrl_pkg::WB_BUS: begin
               if (bus_done) begin
                  rd_valid <= 1'b1;
                  state    <= lookup_ctrl_pkg::WB_RETURN;
               end
            end

            lookup_ctrl_pkg::WB_RETURN: begin
               state <= lookup_ctrl_pkg::WB_IDLE;
            end

            default: state <= lookup_ctrl_pkg::WB_IDLE;
         endcase
      end
   end

   // Address latch and read data capture
   always_ff @(posedge clk) begin
      if (take_req)
         wb_adr <= rd_addr;
      if (bus_done) begin
         rd_data      <= wb_dat_i;
         rd_data_addr <= wb_adr;   // Tags the word for the collector
      end
   end

endmodule

// File: src/entry_data_collector.sv
////////////////////////////////////////
// Collects returned data words into one
// hash-tagged entry result
////////////////////////////////////////

`timescale 1ns/1ps
`include "lookup_settings.svh"

module entry_data_collector (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          rd_valid,
   input  lookup_types_pkg::sram_word_t  rd_data,
   input  lookup_types_pkg::sram_addr_t  rd_data_addr,
   output logic                          entry_valid,
   output lookup_types_pkg::entry_hash_t entry_hash,
   output lookup_types_pkg::entry_data_t entry_data
);

   localparam int SLOT_BITS = ($clog2(`LK_NUM_DATA_WORDS) > 0) ?
                              $clog2(`LK_NUM_DATA_WORDS) : 1;

   lookup_types_pkg::entry_hash_t word_hash;
   lookup_types_pkg::word_idx_t   word_idx;
   lookup_types_pkg::word_idx_t   slot_full;
   logic [SLOT_BITS-1:0]          slot;
   logic                          is_data;
   logic                          is_last;
   lookup_types_pkg::entry_data_t data_buf;
   lookup_types_pkg::entry_data_t entry_next;

   // Address is {hash, index}
   assign word_hash = rd_data_addr[`LK_SRAM_ADDR_WIDTH-1 -: `LK_HASH_WIDTH];
   assign word_idx  = rd_data_addr[`LK_IDX_WIDTH-1:0];

   assign slot_full = word_idx - lookup_types_pkg::word_idx_t'(`LK_NUM_RULE_WORDS);
   assign slot      = slot_full[SLOT_BITS-1:0];
   assign is_data   = (word_idx >= lookup_types_pkg::word_idx_t'(`LK_NUM_RULE_WORDS));
   assign is_last   = (word_idx == lookup_types_pkg::word_idx_t'(
                          `LK_NUM_RULE_WORDS + `LK_NUM_DATA_WORDS - 1));

   // Buffer with the incoming word merged in
   always_comb begin
      entry_next = data_buf;
      entry_next[slot*`LK_WORD_WIDTH +: `LK_WORD_WIDTH] = rd_data;
   end

   always_ff @(posedge clk) begin
      if (rd_valid && is_data)
         data_buf <= entry_next;
      if (rd_valid && is_last) begin
         entry_data <= entry_next;   // Last word goes straight out
         entry_hash <= word_hash;
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         entry_valid <= 1'b0;
      else
         entry_valid <= rd_valid && is_last;
   end

endmodule

// File: src/lookup_data_reader.sv
////////////////////////////////////////
// Top of the lookup data-fetch stage
////////////////////////////////////////

`timescale 1ns/1ps
`include "lookup_settings.svh"

module lookup_data_reader (
   input  logic                          clk,
   input  logic                          reset,

   // From the rule checker
   input  logic                          entry_hit,
   input  lookup_types_pkg::entry_hash_t found_entry_hash,
   output logic                          hit_full,

   // SRAM over Wishbone
   input  lookup_types_pkg::sram_word_t  wb_dat_i,
   input  logic                          wb_ack,
   output logic                          wb_cyc,
   output logic                          wb_stb,
   output logic                          wb_we,
   output lookup_types_pkg::sram_addr_t  wb_adr,

   // Entry results without back-pressure
   output logic                          entry_valid,
   output lookup_types_pkg::entry_hash_t entry_hash,
   output lookup_types_pkg::entry_data_t entry_data
);

   lookup_types_pkg::entry_hash_t hash_out;
   logic                          hash_empty;
   logic                          hash_pop;
   logic                          rd_req;
   logic                          rd_rdy;
   lookup_types_pkg::sram_addr_t  rd_addr;
   logic                          rd_valid;
   lookup_types_pkg::sram_word_t  rd_data;
   lookup_types_pkg::sram_addr_t  rd_data_addr;

   hit_fifo #(
      .DEPTH_BITS (1)   // Two hashes
   ) hit_fifo_i (
      .clk       (clk),
      .reset     (reset),
      .push      (entry_hit),
      .push_hash (found_entry_hash),
      .pop       (hash_pop),
      .head_hash (hash_out),
      .empty     (hash_empty),
      .full      (hit_full)
   );

   data_read_issuer data_read_issuer_i (
      .clk        (clk),
      .reset      (reset),
      .hash_empty (hash_empty),
      .hash_out   (hash_out),
      .rd_rdy     (rd_rdy),
      .hash_pop   (hash_pop),
      .rd_req     (rd_req),
      .rd_addr    (rd_addr)
   );

   sram_wb_master sram_wb_master_i (
      .clk          (clk),
      .reset        (reset),
      .rd_req       (rd_req),
      .rd_addr      (rd_addr),
      .rd_rdy       (rd_rdy),
      .wb_dat_i     (wb_dat_i),
      .wb_ack       (wb_ack),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .rd_valid     (rd_valid),
      .rd_data      (rd_data),
      .rd_data_addr (rd_data_addr)
   );

   entry_data_collector entry_data_collector_i (
      .clk          (clk),
      .reset        (reset),
      .rd_valid     (rd_valid),
      .rd_data      (rd_data),
      .rd_data_addr (rd_data_addr),
      .entry_valid  (entry_valid),
      .entry_hash   (entry_hash),
      .entry_data   (entry_data)
   );

endmodule

// File: bench/wb_sram_model.sv
////////////////////////////////////////
// Wishbone classic SRAM slave model with
// rule-based contents and random ack delay
////////////////////////////////////////

`timescale 1ns/1ps
`include "lookup_settings.svh"

module wb_sram_model (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         wb_cyc,
   input  logic                         wb_stb,
   input  logic                         wb_we,
   input  lookup_types_pkg::sram_addr_t wb_adr,
   output lookup_types_pkg::sram_word_t wb_dat_o,
   output logic                         wb_ack,
   output int                           protocol_errors
);

   localparam int DRIVE_DELAY = 10;

   logic [31:0] lcg_state;
   logic        busy;       // Transfer open and not yet acked
   int          wait_left;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Upper half tags the address and lower half is its inverse
   function automatic lookup_types_pkg::sram_word_t word_at(
      input lookup_types_pkg::sram_addr_t addr
   );
      logic [31:0] addr32;
      addr32 = 32'(addr);
      return {32'hC0DE0000 + addr32, ~addr32};
   endfunction

   initial begin
      wb_ack          = 1'b0;
      wb_dat_o        = '0;
      protocol_errors = 0;
      busy            = 1'b0;
      wait_left       = 0;
      lcg_state       = 32'hd3e90e93;
      forever begin
         @(posedge clk);
         #DRIVE_DELAY;
         if (reset) begin
            wb_ack = 1'b0;
            busy   = 1'b0;
         end else begin
            if (wb_we) begin
               protocol_errors++;
               $display("ERROR: write request seen at address 0x%h, time %0t", wb_adr, $time);
            end
            if (wb_stb && !wb_cyc) begin
               protocol_errors++;
               $display("ERROR: stb high without cyc at time %0t", $time);
            end
            if (wb_ack) begin
               wb_ack = 1'b0;   // Master took the word at the last edge
               busy   = 1'b0;
            end else if (busy && !(wb_cyc && wb_stb)) begin
               protocol_errors++;
               $display("ERROR: stb dropped before ack at time %0t", $time);
               busy = 1'b0;
            end
            if (wb_cyc && wb_stb && !busy) begin
               busy      = 1'b1;
               lcg_state = lcg_next(lcg_state);
               wait_left = int'(lcg_state[17:16]);   // 0 to 3 cycles
            end
            if (busy) begin
               if (wait_left == 0) begin
                  wb_ack   = 1'b1;
                  wb_dat_o = word_at(wb_adr);
               end else begin
                  wait_left--;
               end
            end
         end
      end
   end

endmodule

// File: bench/lookup_data_reader_tb.sv
////////////////////////////////////////
// Testbench for the lookup data reader
// with file-driven hits and result checks
////////////////////////////////////////

`timescale 1ns/1ps
`include "lookup_settings.svh"

module lookup_data_reader_tb;

   localparam int CLK_PERIOD   = 100;
   localparam int DRIVE_DELAY  = 10;
   localparam int RESET_CYCLES = 4;
   localparam int DRAIN_CYCLES = 20;   // Room for a stray extra result

   logic                          clk;
   logic                          reset;
   logic                          entry_hit;
   lookup_types_pkg::entry_hash_t found_entry_hash;
   logic                          hit_full;
   lookup_types_pkg::sram_word_t  wb_dat_i;
   logic                          wb_ack;
   logic                          wb_cyc;
   logic                          wb_stb;
   logic                          wb_we;
   lookup_types_pkg::sram_addr_t  wb_adr;
   logic                          entry_valid;
   lookup_types_pkg::entry_hash_t entry_hash;
   lookup_types_pkg::entry_data_t entry_data;

   lookup_types_pkg::entry_hash_t stim_hash[$];
   int                            stim_gap[$];
   lookup_types_pkg::entry_data_t stim_data[$];
   int                            num_lines;
   logic                          stim_ok;

   // Outstanding expectations with the oldest at the front
   lookup_types_pkg::entry_hash_t exp_hash_q[$];
   lookup_types_pkg::entry_data_t exp_data_q[$];
   lookup_types_pkg::sram_addr_t  exp_addr_q[$];

   int   check_errors;
   int   model_errors;
   int   results_seen;
   int   cycle_count;
   int   cycle_limit;
   logic limit_ready;
   logic saw_full;
   logic prev_valid;

   lookup_data_reader uut (
      .clk              (clk),
      .reset            (reset),
      .entry_hit        (entry_hit),
      .found_entry_hash (found_entry_hash),
      .hit_full         (hit_full),
      .wb_dat_i         (wb_dat_i),
      .wb_ack           (wb_ack),
      .wb_cyc           (wb_cyc),
      .wb_stb           (wb_stb),
      .wb_we            (wb_we),
      .wb_adr           (wb_adr),
      .entry_valid      (entry_valid),
      .entry_hash       (entry_hash),
      .entry_data       (entry_data)
   );

   wb_sram_model sram (
      .clk             (clk),
      .reset           (reset),
      .wb_cyc          (wb_cyc),
      .wb_stb          (wb_stb),
      .wb_we           (wb_we),
      .wb_adr          (wb_adr),
      .wb_dat_o        (wb_dat_i),
      .wb_ack          (wb_ack),
      .protocol_errors (model_errors)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   task automatic check_hash(input string name, input lookup_types_pkg::entry_hash_t got,
                             input lookup_types_pkg::entry_hash_t exp);
      if (got !== exp) begin
         check_errors++;
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_data(input string name, input lookup_types_pkg::entry_data_t got,
                             input lookup_types_pkg::entry_data_t exp);
      if (got !== exp) begin
         check_errors++;
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_addr(input string name, input lookup_types_pkg::sram_addr_t got,
                             input lookup_types_pkg::sram_addr_t exp);
      if (got !== exp) begin
         check_errors++;
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic expect_low(input string name, input logic value);
      if (value !== 1'b0) begin
         check_errors++;
         $display("CHECK FAILED %s: got 0x%h, expected 0x0 at %0t", name, value, $time);
      end
   endtask

   task automatic verify_idle_outputs();
      expect_low("wb_cyc", wb_cyc);
      expect_low("wb_stb", wb_stb);
      expect_low("entry_valid", entry_valid);
      expect_low("hit_full", hit_full);
   endtask

   // Lines that do not start with a hash value are skipped
   task automatic read_stim();
      int                            fd;
      int                            n;
      int                            c;
      lookup_types_pkg::entry_hash_t h;
      logic [31:0]                   g;
      lookup_types_pkg::entry_data_t d;
      fd      = $fopen("bench/lookup_stim.txt", "r");
      stim_ok = 1'b0;
      if (fd == 0) begin
         check_errors++;
         $display("ERROR: cannot open bench/lookup_stim.txt");
      end else begin
         while (!$feof(fd)) begin
            n = $fscanf(fd, "%h %d %h", h, g, d);
            if (n == 3) begin
               stim_hash.push_back(h);
               stim_gap.push_back(int'(g));
               stim_data.push_back(d);
            end else begin
               if (n > 0) begin
                  check_errors++;
                  $display("ERROR: stim entry %0d is incomplete", stim_hash.size() + 1);
               end
               c = $fgetc(fd);
               while (c != -1 && c != 10)   // To end of line
                  c = $fgetc(fd);
            end
         end
         $fclose(fd);
         num_lines = stim_hash.size();
         stim_ok   = (num_lines > 0);
         if (!stim_ok) begin
            check_errors++;
            $display("ERROR: stim file holds no hits");
         end
      end
   endtask

   task automatic push_hit(input lookup_types_pkg::entry_hash_t h,
                           input lookup_types_pkg::entry_data_t d);
      lookup_types_pkg::word_idx_t first_idx;
      lookup_types_pkg::word_idx_t second_idx;
      first_idx  = lookup_types_pkg::word_idx_t'(`LK_NUM_RULE_WORDS);
      second_idx = first_idx + lookup_types_pkg::word_idx_t'(1);
      while (hit_full) begin   // Upstream must honor the full flag
         @(posedge clk);
         #DRIVE_DELAY;
      end
      exp_hash_q.push_back(h);
      exp_data_q.push_back(d);
      exp_addr_q.push_back(lookup_types_pkg::sram_addr_t'({h, first_idx}));
      exp_addr_q.push_back(lookup_types_pkg::sram_addr_t'({h, second_idx}));
      entry_hit        = 1'b1;
      found_entry_hash = h;
      @(posedge clk);
      #DRIVE_DELAY;
      entry_hit = 1'b0;
   endtask

   task automatic print_summary();
      $display("Summary: %0d check errors, %0d bus protocol errors, %0d of %0d results",
               check_errors, model_errors, results_seen, num_lines);
   endtask

   // Main sequence
   initial begin
      int i;
      reset            = 1'b1;
      entry_hit        = 1'b0;
      found_entry_hash = '0;
      check_errors     = 0;
      results_seen     = 0;
      saw_full         = 1'b0;
      prev_valid       = 1'b0;
      limit_ready      = 1'b0;
      num_lines        = 0;
      read_stim();
      cycle_limit = 40 * num_lines + 100;
      limit_ready = 1'b1;

      repeat (RESET_CYCLES) begin
         @(posedge clk);
         #DRIVE_DELAY;
         verify_idle_outputs();
      end
      reset = 1'b0;
      @(posedge clk);
      #DRIVE_DELAY;
      verify_idle_outputs();   // First cycle out of reset

      if (stim_ok) begin
         for (i = 0; i < num_lines; i++) begin
            repeat (stim_gap[i]) begin
               @(posedge clk);
               #DRIVE_DELAY;
            end
            push_hit(stim_hash[i], stim_data[i]);
         end
         while (results_seen < num_lines)
            @(posedge clk);
         repeat (DRAIN_CYCLES) @(posedge clk);

         if (results_seen != num_lines) begin
            check_errors++;
            $display("ERROR: %0d results seen for %0d hits", results_seen, num_lines);
         end
         if (exp_addr_q.size() != 0) begin
            check_errors++;
            $display("ERROR: %0d expected SRAM reads never completed", exp_addr_q.size());
         end
         if (!saw_full) begin
            check_errors++;
            $display("ERROR: hit_full never rose during back-to-back hits");
         end
      end

      print_summary();
      if (check_errors == 0 && model_errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   // Output monitor sampled mid-cycle
   initial begin
      forever begin
         @(negedge clk);
         if (reset) begin
            prev_valid = 1'b0;
         end else begin
            if (hit_full)
               saw_full = 1'b1;
            if (wb_cyc && wb_stb && wb_ack) begin
               if (exp_addr_q.size() == 0) begin
                  check_errors++;
                  $display("ERROR: SRAM read of 0x%h with no read outstanding", wb_adr);
               end else begin
                  check_addr("wb_adr", wb_adr, exp_addr_q.pop_front());
               end
            end
            if (entry_valid && prev_valid) begin
               check_errors++;
               $display("ERROR: entry_valid held high for more than one cycle at %0t", $time);
            end else if (entry_valid) begin
               results_seen++;
               if (exp_hash_q.size() == 0) begin
                  check_errors++;
                  $display("ERROR: entry_valid with no hit outstanding at %0t", $time);
               end else begin
                  check_hash("entry_hash", entry_hash, exp_hash_q.pop_front());
                  check_data("entry_data", entry_data, exp_data_q.pop_front());
               end
            end
            prev_valid = entry_valid;
         end
      end
   end

   // Watchdog
   initial begin
      cycle_count = 0;
      wait (limit_ready);
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      check_errors++;
      $display("ERROR: timeout after %0d cycles with %0d of %0d results seen",
               cycle_count, results_seen, num_lines);
      print_summary();
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+src
src/lookup_types_pkg.sv
src/lookup_ctrl_pkg.sv
src/hit_fifo.sv
src/data_read_issuer.sv
src/sram_wb_master.sv
src/entry_data_collector.sv
src/lookup_data_reader.sv
bench/wb_sram_model.sv
bench/lookup_data_reader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the lookup data reader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
   --top-module lookup_data_reader_tb -o lookup_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/lookup_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx '=== PASS ==='; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: bench/lookup_stim.txt
# hash (hex)  idle cycles before the hit (decimal)  entry data (hex)
# entry data is the word at {hash,7} then the word at {hash,6}
00 2 c0de0007fffffff8c0de0006fffffff9
01 20 c0de000ffffffff0c0de000efffffff1
2a 20 c0de0157fffffea8c0de0156fffffea9
ff 0 c0de07fffffff800c0de07fefffff801
80 0 c0de0407fffffbf8c0de0406fffffbf9
13 0 c0de009fffffff60c0de009effffff61
7e 0 c0de03f7fffffc08c0de03f6fffffc09
55 3 c0de02affffffd50c0de02aefffffd51
aa 0 c0de0557fffffaa8c0de0556fffffaa9
3c 0 c0de01e7fffffe18c0de01e6fffffe19
c3 5 c0de061ffffff9e0c0de061efffff9e1
10 0 c0de0087ffffff78c0de0086ffffff79
11 0 c0de008fffffff70c0de008effffff71
12 0 c0de0097ffffff68c0de0096ffffff69
f0 1 c0de0787fffff878c0de0786fffff879
0f 0 c0de007fffffff80c0de007effffff81
99 0 c0de04cffffffb30c0de04cefffffb31
66 0 c0de0337fffffcc8c0de0336fffffcc9
2a 0 c0de0157fffffea8c0de0156fffffea9
